// ==== hdl/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

    //////////////////////////////////////////////////////////////////////
    // datapath types
    //////////////////////////////////////////////////////////////////////

    localparam int OP_W   = 4;
    localparam int PROD_W = 2 * OP_W;

    typedef logic [OP_W-1:0]   op_t;    // unsigned operand
    typedef logic [PROD_W-1:0] prod_t;  // full-width product, never overflows

    //////////////////////////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////////////////////////

    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    localparam reg_addr_t ADDR_CTRL   = 2'd0;  // rw, accumulate and saturate enables
    localparam reg_addr_t ADDR_CLEAR  = 2'd1;  // write of any value clears
    localparam reg_addr_t ADDR_STATUS = 2'd2;  // ro, sticky overflow
    localparam reg_addr_t ADDR_COUNT  = 2'd3;  // ro, samples since last clear

    // bit positions inside CTRL
    localparam int CTRL_ACC_BIT = 0;
    localparam int CTRL_SAT_BIT = 1;

    // bit positions inside STATUS
    localparam int STATUS_OVF_BIT = 0;

endpackage

`default_nettype wire

// ==== hdl/kogge_stone_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module kogge_stone_add #(
    parameter int WIDTH = 8
) (
    input  wire [WIDTH-1:0] x,
    input  wire [WIDTH-1:0] y,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    localparam int LEVELS = $clog2(WIDTH);

    // row 0 holds the bitwise generate and propagate terms, row l the group
    // terms spanning 2**l bits ending at each position
    wire [WIDTH-1:0] g [0:LEVELS];
    wire [WIDTH-1:0] p [0:LEVELS];

    assign g[0] = x & y;
    assign p[0] = x ^ y;

    //////////////////////////////////////////////////////////////////////
    // prefix tree
    //////////////////////////////////////////////////////////////////////

    for (genvar l = 1; l <= LEVELS; l++) begin : g_level
        localparam int D = 1 << (l - 1);  // span of the cells at this level

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (i < D) begin : g_pass
                // already resolved down to bit 0
                assign g[l][i] = g[l-1][i];
                assign p[l][i] = p[l-1][i];
            end else if (i < 2 * D) begin : g_gray
                // gray cell, the lower group reaches bit 0 so only the
                // generate term is still needed
                assign g[l][i] = g[l-1][i] | (p[l-1][i] & g[l-1][i-D]);
                assign p[l][i] = p[l-1][i];
            end else begin : g_black
                assign g[l][i] = g[l-1][i] | (p[l-1][i] & g[l-1][i-D]);
                assign p[l][i] = p[l-1][i] & p[l-1][i-D];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sum bits
    //////////////////////////////////////////////////////////////////////

    // the carry into bit i is the group generate of bits i-1 down to 0
    assign sum  = p[0] ^ {g[LEVELS][WIDTH-2:0], 1'b0};
    assign cout = g[LEVELS][WIDTH-1];

endmodule

`default_nettype wire

// ==== hdl/dadda_mult_4.sv ====
`timescale 1ns/1ps
`default_nettype none

module dadda_mult_4 import mac_pkg::*; (
    input  wire op_t a,
    input  wire op_t b,
    output prod_t    product
);

    // pp[j][i] = a[i] & b[j] has weight i + j
    wire [3:0] pp [0:3];

    for (genvar j = 0; j < 4; j++) begin : g_pp
        assign pp[j] = a & {4{b[j]}};
    end

    //////////////////////////////////////////////////////////////////////
    // first stage, column heights down to 3
    //////////////////////////////////////////////////////////////////////

    wire s11, c11;  // weight 3 half adder
    wire s12, c12;  // weight 4 half adder

    assign s11 = pp[3][0] ^ pp[2][1];
    assign c11 = pp[3][0] & pp[2][1];

    assign s12 = pp[3][1] ^ pp[2][2];
    assign c12 = pp[3][1] & pp[2][2];

    //////////////////////////////////////////////////////////////////////
    // second stage, column heights down to 2
    //////////////////////////////////////////////////////////////////////

    wire s21, c21;  // weight 2 half adder
    wire s22, c22;  // weight 3 full adder
    wire s23, c23;  // weight 4 full adder
    wire s24, c24;  // weight 5 full adder

    assign s21 = pp[2][0] ^ pp[1][1];
    assign c21 = pp[2][0] & pp[1][1];

    assign s22 = pp[1][2] ^ pp[0][3] ^ s11;
    assign c22 = (pp[1][2] & pp[0][3]) | (pp[1][2] & s11) | (pp[0][3] & s11);

    assign s23 = pp[1][3] ^ s12 ^ c11;
    assign c23 = (pp[1][3] & s12) | (pp[1][3] & c11) | (s12 & c11);

    assign s24 = pp[2][3] ^ pp[3][2] ^ c12;
    assign c24 = (pp[2][3] & pp[3][2]) | (pp[2][3] & c12) | (pp[3][2] & c12);

    //////////////////////////////////////////////////////////////////////
    // final carry-propagate add over weights 1 to 6
    //////////////////////////////////////////////////////////////////////

    wire [5:0] row_x;
    wire [5:0] row_y;
    wire [5:0] ks_sum;
    wire       ks_cout;

    assign row_x = {pp[3][3], s24, s23, s22, s21, pp[0][1]};
    assign row_y = {c24, c23, c22, c21, pp[0][2], pp[1][0]};

    kogge_stone_add #(
        .WIDTH (6)
    ) u_final_add (
        .x    (row_x),
        .y    (row_y),
        .sum  (ks_sum),
        .cout (ks_cout)
    );

    // weight 0 has a single bit and skips the adder
    assign product = {ks_cout, ks_sum, pp[0][0]};

endmodule

`default_nettype wire

// ==== hdl/mac_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_datapath import mac_pkg::*; #(
    parameter int ACC_W = 16
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              in_valid,
    input  wire op_t         a,
    input  wire op_t         b,
    input  wire              acc_en,
    input  wire              sat_en,
    input  wire              clear_pulse,
    output logic             out_valid,
    output prod_t            product,
    output logic [ACC_W-1:0] acc,
    output logic             ovf_event
);

    op_t              a_q;
    op_t              b_q;
    logic             v1;         // a sample sits in stage two
    prod_t            prod_s2;
    logic [ACC_W-1:0] acc_base;
    logic [ACC_W-1:0] add_x;
    logic [ACC_W-1:0] add_y;
    logic [ACC_W-1:0] add_sum;
    logic             add_cout;
    logic             ovf_s2;
    logic [ACC_W-1:0] acc_nxt;

    //////////////////////////////////////////////////////////////////////
    // stage one, operand register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1 <= 1'b0;
        end else begin
            v1 <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q <= a;
            b_q <= b;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage two, multiply and accumulate
    //////////////////////////////////////////////////////////////////////

    dadda_mult_4 u_mult (
        .a       (a_q),
        .b       (b_q),
        .product (prod_s2)
    );

    assign acc_base = clear_pulse ? '0 : acc;  // a clear in the same cycle wins over the old sum
    assign add_x    = acc_en ? acc_base : '0;  // with accumulation off the product is loaded
    assign add_y    = ACC_W'(prod_s2);

    kogge_stone_add #(
        .WIDTH (ACC_W)
    ) u_acc_add (
        .x    (add_x),
        .y    (add_y),
        .sum  (add_sum),
        .cout (add_cout)
    );

    assign ovf_s2  = v1 & add_cout;
    assign acc_nxt = (ovf_s2 && sat_en) ? '1 : add_sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            ovf_event <= 1'b0;
            acc       <= '0;
        end else begin
            out_valid <= v1;
            ovf_event <= ovf_s2;
            if (v1) begin
                acc <= acc_nxt;
            end else if (clear_pulse) begin
                acc <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (v1) begin
            product <= prod_s2;
        end
    end

    // fixed two-cycle latency, nothing is ever held back
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2));

    a_ovf_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ovf_event |-> out_valid);

endmodule

`default_nettype wire

// ==== hdl/mac_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_config import mac_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire reg_data_t wr_data,
    input  wire            rd_en,
    input  wire reg_addr_t rd_addr,
    input  wire            out_valid,
    input  wire            ovf_event,
    output logic           acc_en,
    output logic           sat_en,
    output logic           clear_pulse,
    output logic           rd_valid,
    output reg_data_t      rd_data
);

    logic      ctrl_acc;
    logic      ctrl_sat;
    logic      ovf_sticky;
    reg_data_t sample_cnt;
    reg_data_t rd_mux;

    assign acc_en = ctrl_acc;
    assign sat_en = ctrl_sat;

    //////////////////////////////////////////////////////////////////////
    // control register and status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_acc    <= 1'b0;
            ctrl_sat    <= 1'b0;
            clear_pulse <= 1'b0;
            ovf_sticky  <= 1'b0;
            sample_cnt  <= '0;
            rd_valid    <= 1'b0;
        end else begin
            if (wr_en && wr_addr == ADDR_CTRL) begin
                ctrl_acc <= wr_data[CTRL_ACC_BIT];
                ctrl_sat <= wr_data[CTRL_SAT_BIT];
            end
            clear_pulse <= wr_en && wr_addr == ADDR_CLEAR;  // data is ignored
            if (clear_pulse) begin
                // same edge that zeroes the accumulator
                ovf_sticky <= 1'b0;
                sample_cnt <= '0;
            end else begin
                ovf_sticky <= ovf_sticky | ovf_event;
                if (out_valid) begin
                    sample_cnt <= sample_cnt + 1'b1;  // wraps at 16 bits
                end
            end
            rd_valid <= rd_en;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_mux = '0;
        case (rd_addr)
            ADDR_CTRL: begin
                rd_mux[CTRL_ACC_BIT] = ctrl_acc;
                rd_mux[CTRL_SAT_BIT] = ctrl_sat;
            end
            ADDR_STATUS: rd_mux[STATUS_OVF_BIT] = ovf_sticky;
            ADDR_COUNT:  rd_mux = sample_cnt;
            default:     rd_mux = '0;  // CLEAR reads back as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_mux;
        end
    end

    // back-to-back CLEAR writes would stretch the pulse and wipe a sample
    a_clear_single: assert property (@(posedge clk) disable iff (!rst_n)
        clear_pulse |=> !clear_pulse);

endmodule

`default_nettype wire

// ==== hdl/mac_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_top import mac_pkg::*; #(
    parameter int ACC_W = 16
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              in_valid,
    input  wire op_t         a,
    input  wire op_t         b,
    input  wire              wr_en,
    input  wire reg_addr_t   wr_addr,
    input  wire reg_data_t   wr_data,
    input  wire              rd_en,
    input  wire reg_addr_t   rd_addr,
    output logic             out_valid,
    output prod_t            product,
    output logic [ACC_W-1:0] acc,
    output logic             rd_valid,
    output reg_data_t        rd_data
);

    logic acc_en;
    logic sat_en;
    logic clear_pulse;
    logic ovf_event;  // back from the datapath into the sticky flag

    mac_config u_config (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .out_valid   (out_valid),
        .ovf_event   (ovf_event),
        .acc_en      (acc_en),
        .sat_en      (sat_en),
        .clear_pulse (clear_pulse),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    mac_datapath #(
        .ACC_W (ACC_W)
    ) u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .a           (a),
        .b           (b),
        .acc_en      (acc_en),
        .sat_en      (sat_en),
        .clear_pulse (clear_pulse),
        .out_valid   (out_valid),
        .product     (product),
        .acc         (acc),
        .ovf_event   (ovf_event)
    );

endmodule

`default_nettype wire

// ==== sim/mac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_tb import mac_pkg::*; ();

    localparam int          ACC_W     = 16;
    localparam int          TIMEOUT   = 100;  // cycles allowed for any single wait
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic             clk;
    logic             rst_n    = 1'b0;
    logic             in_valid = 1'b0;
    op_t              a        = '0;
    op_t              b        = '0;
    logic             wr_en    = 1'b0;
    reg_addr_t        wr_addr  = '0;
    reg_data_t        wr_data  = '0;
    logic             rd_en    = 1'b0;
    reg_addr_t        rd_addr  = '0;
    logic             out_valid;
    prod_t            product;
    logic [ACC_W-1:0] acc;
    logic             rd_valid;
    reg_data_t        rd_data;

    // model state is updated when a sample or a write is issued
    logic [ACC_W-1:0] ref_acc   = '0;
    reg_data_t        ref_count = '0;
    logic             ref_ovf   = 1'b0;
    logic             tb_acc_en = 1'b0;
    logic             tb_sat_en = 1'b0;

    prod_t            exp_prod_q [$];
    logic [ACC_W-1:0] exp_acc_q  [$];
    int               in_cycle_q [$];
    int               cycle_cnt       = 0;
    int               issue_cycle;
    logic             rd_en_q         = 1'b0;  // read request seen one cycle earlier
    int               mismatch_errors = 0;
    int               other_errors    = 0;
    string            test_name       = "reset";
    logic [31:0]      lfsr_state      = 32'hc5a5f5bd;

    mac_top #(
        .ACC_W (ACC_W)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .out_valid (out_valid),
        .product   (product),
        .acc       (acc),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    //////////////////////////////////////////////////////////////////////
    // reference model and random source
    //////////////////////////////////////////////////////////////////////

    // returns {overflow, next accumulator, product}
    function automatic logic [ACC_W+PROD_W:0] ref_mac(input op_t x, input op_t y,
            input logic [ACC_W-1:0] acc_now, input logic en_acc, input logic en_sat);
        prod_t            p;
        logic [ACC_W:0]   s;
        logic [ACC_W-1:0] nxt;
        p   = prod_t'(x) * prod_t'(y);
        s   = (ACC_W+1)'(en_acc ? acc_now : '0) + (ACC_W+1)'(p);
        nxt = (s[ACC_W] && en_sat) ? '1 : s[ACC_W-1:0];
        return {s[ACC_W], nxt, p};
    endfunction

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks and report
    //////////////////////////////////////////////////////////////////////

    task automatic check_product(input string name, input prod_t exp, input prod_t act);
        if (exp !== act) begin
            mismatch_errors++;
            $display("mismatch %s product: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_acc(input string name, input logic [ACC_W-1:0] exp,
            input logic [ACC_W-1:0] act);
        if (exp !== act) begin
            mismatch_errors++;
            $display("mismatch %s acc: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
        if (exp !== act) begin
            mismatch_errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        other_errors++;
        $display("timeout in %s while waiting for %s", test_name, what);
        finish_run();
    endtask

    // outputs are sampled on the falling edge half a cycle after they change
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_valid) in_cycle_q.push_back(cycle_cnt);
            if (out_valid) begin
                if (exp_prod_q.size() == 0 || in_cycle_q.size() == 0) begin
                    other_errors++;
                    $display("out_valid in %s with no sample in flight", test_name);
                end else begin
                    check_product(test_name, exp_prod_q.pop_front(), product);
                    check_acc(test_name, exp_acc_q.pop_front(), acc);
                    issue_cycle = in_cycle_q.pop_front();
                    if (cycle_cnt - issue_cycle != 2) begin
                        mismatch_errors++;
                        $display("mismatch %s latency: expected 2, actual %0d",
                                 test_name, cycle_cnt - issue_cycle);
                    end
                end
            end
            // a read answers exactly one cycle after its request
            if (rd_valid !== rd_en_q) begin
                mismatch_errors++;
                $display("mismatch %s rd_valid: expected %b, actual %b",
                         test_name, rd_en_q, rd_valid);
            end
            rd_en_q = rd_en;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic send_sample(input op_t x, input op_t y);
        logic [ACC_W+PROD_W:0] r;
        r = ref_mac(x, y, ref_acc, tb_acc_en, tb_sat_en);
        exp_prod_q.push_back(r[PROD_W-1:0]);
        exp_acc_q.push_back(r[ACC_W+PROD_W-1:PROD_W]);
        ref_acc   = r[ACC_W+PROD_W-1:PROD_W];
        ref_ovf   = ref_ovf | r[ACC_W+PROD_W];
        ref_count = ref_count + 16'd1;
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= x;
        b        <= y;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        idle_cycles(2);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en <= 1'b0;
        idle_cycles(1);
        if (addr == ADDR_CTRL) begin
            tb_acc_en = data[CTRL_ACC_BIT];
            tb_sat_en = data[CTRL_SAT_BIT];
        end else if (addr == ADDR_CLEAR) begin
            ref_acc   = '0;
            ref_count = '0;
            ref_ovf   = 1'b0;
        end
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        int   waited;
        logic got;
        @(posedge clk);
        in_valid <= 1'b0;
        rd_en    <= 1'b1;
        rd_addr  <= addr;
        @(posedge clk);
        rd_en  <= 1'b0;
        waited = 0;
        got    = 1'b0;
        data   = '0;
        while (!got && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (rd_valid) begin
                got  = 1'b1;
                data = rd_data;
            end
        end
        if (!got) fail_timeout("rd_valid");
    endtask

    task automatic drain();
        int waited;
        idle_cycles(1);
        waited = 0;
        while (exp_prod_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_prod_q.size() != 0) fail_timeout("results to drain");
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] gap;
        reg_data_t   rd;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(2);

        test_name = "exhaustive";
        write_reg(ADDR_CTRL, 16'h0000);
        for (int i = 0; i < 256; i++) send_sample(op_t'(i >> 4), op_t'(i));  // back to back
        drain();
        read_reg(ADDR_COUNT, rd);
        check_reg("exhaustive COUNT", ref_count, rd);

        test_name = "wrap";
        write_reg(ADDR_CLEAR, 16'h0000);
        write_reg(ADDR_CTRL, 16'h0001);
        for (int i = 0; i < 1500; i++) begin  // enough to wrap 16 bits once
            random_bits(8, r);
            send_sample(op_t'(r >> 4), op_t'(r));
            random_bits(2, gap);
            idle_cycles(int'(gap));
        end
        drain();
        read_reg(ADDR_COUNT, rd);
        check_reg("wrap COUNT", ref_count, rd);
        read_reg(ADDR_STATUS, rd);
        check_reg("wrap STATUS", reg_data_t'(ref_ovf), rd);

        test_name = "saturate";
        write_reg(ADDR_CLEAR, 16'h0000);
        write_reg(ADDR_CTRL, 16'h0003);
        for (int i = 0; i < 400; i++) send_sample(4'hf, 4'hf);
        drain();
        read_reg(ADDR_STATUS, rd);
        check_reg("saturate STATUS", 16'h0001, rd);
        read_reg(ADDR_CTRL, rd);
        check_reg("saturate CTRL", 16'h0003, rd);

        test_name = "clear";
        write_reg(ADDR_CLEAR, 16'h0000);
        read_reg(ADDR_COUNT, rd);
        check_reg("clear COUNT", 16'h0000, rd);
        read_reg(ADDR_STATUS, rd);
        check_reg("clear STATUS", 16'h0000, rd);
        random_bits(8, r);
        send_sample(op_t'(r >> 4), op_t'(r));  // acc must equal this product
        drain();
        read_reg(ADDR_COUNT, rd);
        check_reg("clear COUNT after sample", 16'h0001, rd);

        finish_run();
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/mac_pkg.sv
hdl/kogge_stone_add.sv
hdl/dadda_mult_4.sv
hdl/mac_datapath.sv
hdl/mac_config.sv
hdl/mac_top.sv
sim/mac_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = mac_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Done: no errors" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
